// ==== Bender.yml ====
package:
  name: soc_fabric

sources:
  # design, package first
  - files:
      - logic/soc_bus_pkg.sv
      - logic/bus_arbiter.sv
      - logic/bus_device_mux.sv
      - logic/sram_device.sv
      - logic/gpio_device.sv
      - logic/timer_device.sv
      - logic/soc_fabric_top.sv

  # testbench
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_soc_fabric.sv

// ==== logic/bus_arbiter.sv ====
// fixed-priority arbiter for the bus hosts
// grants the lowest requesting host in the same cycle and steers the
// response of the following cycle back to that host only
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,

  input  soc_bus_pkg::bus_req_t host_req_i [soc_bus_pkg::NrHosts],
  output soc_bus_pkg::bus_rsp_t host_rsp_o [soc_bus_pkg::NrHosts],

  output soc_bus_pkg::bus_req_t bus_req_o,
  input  logic                  bus_rvalid_i,
  input  soc_bus_pkg::bus_data_t bus_rdata_i,
  input  logic                  bus_err_i
);

  // winner of this cycle and the host owning the response in flight
  soc_bus_pkg::bus_host_e host_sel_d;
  soc_bus_pkg::bus_host_e host_sel_q;

  // walk down from the highest index so the lowest requester is left
  always_comb begin
    host_sel_d = soc_bus_pkg::HostCore;
    bus_req_o  = '0;
    for (int i = soc_bus_pkg::NrHosts - 1; i >= 0; i--) begin
      if (host_req_i[i].req) begin
        host_sel_d = soc_bus_pkg::bus_host_e'(i);
        bus_req_o  = host_req_i[i];
      end
    end
  end

  // remember who was granted, response comes back next cycle
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      host_sel_q <= soc_bus_pkg::HostCore;
    end else if (bus_req_o.req) begin
      host_sel_q <= host_sel_d;
    end
  end

  for (genvar h = 0; h < soc_bus_pkg::NrHosts; h++) begin : g_host_rsp
    logic granted;
    logic owner;

    // gnt is purely combinational on req
    assign granted = host_req_i[h].req && (host_sel_d == soc_bus_pkg::bus_host_e'(h));
    // response only to the registered winner
    assign owner   = bus_rvalid_i && (host_sel_q == soc_bus_pkg::bus_host_e'(h));

    assign host_rsp_o[h] = '{
      gnt:    granted,
      rvalid: owner,
      rdata:  owner ? bus_rdata_i : '0,
      err:    owner & bus_err_i
    };
  end

endmodule

// ==== logic/bus_device_mux.sv ====
// address decoder and response mux for the peer devices
// routes the granted request to the matching window with its offset,
// answers unmapped addresses with an error one cycle later
`timescale 1ns/1ps

module bus_device_mux #(
  parameter int RamWords = 1024
) (
  input  logic                    clk_sys_i,
  input  logic                    rst_sys_ni,

  input  soc_bus_pkg::bus_req_t   bus_req_i,

  output soc_bus_pkg::dev_req_t   dev_req_o [soc_bus_pkg::NrDevices],
  input  soc_bus_pkg::dev_rsp_t   dev_rsp_i [soc_bus_pkg::NrDevices],

  output logic                    bus_rvalid_o,
  output soc_bus_pkg::bus_data_t  bus_rdata_o,
  output logic                    bus_err_o
);

  // ram window follows the ram depth, RamWords must be a power of two
  localparam soc_bus_pkg::bus_addr_t RamMask =
    ~(soc_bus_pkg::bus_addr_t'(RamWords * 4) - 32'd1);

  // map entries, indexed by bus_device_e
  localparam soc_bus_pkg::bus_addr_t DevBase [soc_bus_pkg::NrDevices] =
    '{soc_bus_pkg::RamBase, soc_bus_pkg::GpioBase, soc_bus_pkg::TimerBase};
  localparam soc_bus_pkg::bus_addr_t DevMask [soc_bus_pkg::NrDevices] =
    '{RamMask, soc_bus_pkg::GpioMask, soc_bus_pkg::TimerMask};

  logic [soc_bus_pkg::NrDevices-1:0] hit;
  soc_bus_pkg::bus_device_e          dev_sel_d;
  soc_bus_pkg::bus_device_e          dev_sel_q;
  logic                              err_q;

  // windows never overlap, at most one hit
  always_comb begin
    dev_sel_d = soc_bus_pkg::DevRam;
    for (int d = 0; d < soc_bus_pkg::NrDevices; d++) begin
      hit[d] = (bus_req_i.addr & DevMask[d]) == DevBase[d];
      if (hit[d]) begin
        dev_sel_d = soc_bus_pkg::bus_device_e'(d);
      end
    end
  end

  // only the addressed device sees req
  for (genvar d = 0; d < soc_bus_pkg::NrDevices; d++) begin : g_dev_req
    assign dev_req_o[d] = '{
      req:    bus_req_i.req & hit[d],
      we:     bus_req_i.we,
      be:     bus_req_i.be,
      offset: bus_req_i.addr & ~DevMask[d],
      wdata:  bus_req_i.wdata
    };
  end

  // selection for the response cycle
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      dev_sel_q <= soc_bus_pkg::DevRam;
      err_q     <= 1'b0;
    end else begin
      dev_sel_q <= dev_sel_d;
      // unmapped access gets its own error response
      err_q     <= bus_req_i.req & ~|hit;
    end
  end

  assign bus_rvalid_o = err_q | dev_rsp_i[dev_sel_q].rvalid;
  assign bus_rdata_o  = err_q ? '0 : dev_rsp_i[dev_sel_q].rdata;
  assign bus_err_o    = err_q;

endmodule

// ==== logic/gpio_device.sv ====
// GPIO device with an output register and a synchronised input word
// offset 0 drives gp_o, offset 4 reads gp_i after two flops
`timescale 1ns/1ps

module gpio_device #(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 16
) (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,

  input  soc_bus_pkg::dev_req_t dev_req_i,
  output soc_bus_pkg::dev_rsp_t dev_rsp_o,

  input  logic [GpiWidth-1:0]   gp_i,
  output logic [GpoWidth-1:0]   gp_o
);

  // register word indices within the window
  localparam logic [9:0] GpoWord = 10'd0;
  localparam logic [9:0] GpiWord = 10'd1;

  logic [9:0]             reg_word;
  logic [GpiWidth-1:0]    gpi_meta_q;
  logic [GpiWidth-1:0]    gpi_sync_q;
  soc_bus_pkg::bus_data_t gpo_word;
  soc_bus_pkg::bus_data_t rdata_d;
  soc_bus_pkg::bus_data_t rdata_q;
  logic                   rvalid_q;

  assign reg_word = dev_req_i.offset[11:2];
  assign gpo_word = soc_bus_pkg::bus_data_t'(gp_o);

  // read mux, writes return zero
  always_comb begin
    rdata_d = '0;
    if (!dev_req_i.we) begin
      if (reg_word == GpoWord) begin
        rdata_d = gpo_word;
      end else if (reg_word == GpiWord) begin
        rdata_d = soc_bus_pkg::bus_data_t'(gpi_sync_q);
      end
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gp_o       <= '0;
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      // two-flop input sync
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
      rvalid_q   <= dev_req_i.req;
      // lanes above GpoWidth are dropped
      if (dev_req_i.req && dev_req_i.we && reg_word == GpoWord) begin
        gp_o <= GpoWidth'(soc_bus_pkg::be_merge(gpo_word, dev_req_i.wdata, dev_req_i.be));
      end
    end
  end

  // read data is payload only
  always_ff @(posedge clk_sys_i) begin
    if (dev_req_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  assign dev_rsp_o = '{
    rvalid: rvalid_q,
    rdata:  rdata_q
  };

endmodule

// ==== logic/soc_bus_pkg.sv ====
// shared types and address map for the two-host, three-device bus fabric
// hosts use the req/gnt/rvalid scheme, devices answer one cycle after req
package soc_bus_pkg;

  // widths with a meaning on the bus
  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  bus_be_t;

  // request from a host, held until gnt
  typedef struct packed {
    logic      req;
    logic      we;
    bus_be_t   be;
    bus_addr_t addr;
    bus_data_t wdata;
  } bus_req_t;

  // response back to a host
  typedef struct packed {
    logic      gnt;
    logic      rvalid;
    bus_data_t rdata;
    logic      err;
  } bus_rsp_t;

  // request as a device sees it, offset is relative to the device base
  typedef struct packed {
    logic      req;
    logic      we;
    bus_be_t   be;
    bus_addr_t offset;
    bus_data_t wdata;
  } dev_req_t;

  typedef struct packed {
    logic      rvalid;
    bus_data_t rdata;
  } dev_rsp_t;

  // lower index wins arbitration
  typedef enum logic [0:0] {
    HostCore = 1'b0,
    HostAux  = 1'b1
  } bus_host_e;

  typedef enum logic [1:0] {
    DevRam   = 2'd0,
    DevGpio  = 2'd1,
    DevTimer = 2'd2
  } bus_device_e;

  localparam int NrHosts   = 2;
  localparam int NrDevices = 3;

  // address map, ram window size is set by RamWords
  localparam bus_addr_t RamBase   = 32'h0000_0000;
  localparam bus_addr_t GpioBase  = 32'h8000_0000;
  localparam bus_addr_t GpioMask  = ~(32'd4096 - 32'd1);
  localparam bus_addr_t TimerBase = 32'h8000_2000;
  localparam bus_addr_t TimerMask = ~(32'd4096 - 32'd1);

  // byte-lane merge for register writes
  function automatic bus_data_t be_merge(bus_data_t old_word, bus_data_t new_word,
                                         bus_be_t be);
    bus_data_t merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

// ==== logic/soc_fabric_top.sv ====
// shared-bus fabric top level
// two hosts through a fixed-priority arbiter, decoder to sram, gpio and timer
`timescale 1ns/1ps

module soc_fabric_top #(
  parameter int RamWords = 1024,
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 16
) (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,

  input  soc_bus_pkg::bus_req_t host_req_i [soc_bus_pkg::NrHosts],
  output soc_bus_pkg::bus_rsp_t host_rsp_o [soc_bus_pkg::NrHosts],

  input  logic [GpiWidth-1:0]   gp_i,
  output logic [GpoWidth-1:0]   gp_o,
  output logic                  irq_timer_o
);

  // granted request and its response
  soc_bus_pkg::bus_req_t  bus_req;
  logic                   bus_rvalid;
  soc_bus_pkg::bus_data_t bus_rdata;
  logic                   bus_err;

  // per-device links
  soc_bus_pkg::dev_req_t  dev_req [soc_bus_pkg::NrDevices];
  soc_bus_pkg::dev_rsp_t  dev_rsp [soc_bus_pkg::NrDevices];

  bus_arbiter u_arbiter (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .host_req_i  (host_req_i),
    .host_rsp_o  (host_rsp_o),
    .bus_req_o   (bus_req),
    .bus_rvalid_i(bus_rvalid),
    .bus_rdata_i (bus_rdata),
    .bus_err_i   (bus_err)
  );

  bus_device_mux #(
    .RamWords(RamWords)
  ) u_device_mux (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .bus_req_i   (bus_req),
    .dev_req_o   (dev_req),
    .dev_rsp_i   (dev_rsp),
    .bus_rvalid_o(bus_rvalid),
    .bus_rdata_o (bus_rdata),
    .bus_err_o   (bus_err)
  );

  sram_device #(
    .RamWords(RamWords)
  ) u_sram (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .dev_req_i (dev_req[soc_bus_pkg::DevRam]),
    .dev_rsp_o (dev_rsp[soc_bus_pkg::DevRam])
  );

  gpio_device #(
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth)
  ) u_gpio (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .dev_req_i (dev_req[soc_bus_pkg::DevGpio]),
    .dev_rsp_o (dev_rsp[soc_bus_pkg::DevGpio]),
    .gp_i      (gp_i),
    .gp_o      (gp_o)
  );

  timer_device u_timer (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .dev_req_i  (dev_req[soc_bus_pkg::DevTimer]),
    .dev_rsp_o  (dev_rsp[soc_bus_pkg::DevTimer]),
    .irq_timer_o(irq_timer_o)
  );

endmodule

// ==== logic/sram_device.sv ====
// single-port word SRAM on the device bus
// byte-lane writes, registered read data, answer one cycle after req
`timescale 1ns/1ps

module sram_device #(
  parameter int RamWords = 1024
) (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,

  input  soc_bus_pkg::dev_req_t dev_req_i,
  output soc_bus_pkg::dev_rsp_t dev_rsp_o
);

  localparam int IdxWidth = $clog2(RamWords);

  soc_bus_pkg::bus_data_t mem [RamWords];
  soc_bus_pkg::bus_data_t rdata_q;
  logic                   rvalid_q;
  logic [IdxWidth-1:0]    word_idx;

  // word index, upper offset bits dropped so it wraps
  assign word_idx = dev_req_i.offset[2 +: IdxWidth];

  // storage and read data
  always_ff @(posedge clk_sys_i) begin
    if (dev_req_i.req) begin
      if (dev_req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (dev_req_i.be[b]) begin
            mem[word_idx][8*b +: 8] <= dev_req_i.wdata[8*b +: 8];
          end
        end
        // writes return zero
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  // one-cycle response strobe
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= dev_req_i.req;
    end
  end

  assign dev_rsp_o = '{
    rvalid: rvalid_q,
    rdata:  rdata_q
  };

endmodule

// ==== logic/timer_device.sv ====
// machine timer with mtime and mtimecmp
// mtime counts every cycle unless written, irq is a level while
// mtime is at or past mtimecmp
`timescale 1ns/1ps

module timer_device (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,

  input  soc_bus_pkg::dev_req_t dev_req_i,
  output soc_bus_pkg::dev_rsp_t dev_rsp_o,

  output logic                  irq_timer_o
);

  // register word indices within the window
  localparam logic [9:0] MtimeWord    = 10'd0;
  localparam logic [9:0] MtimecmpWord = 10'd1;

  logic [9:0]             reg_word;
  logic                   mtime_we;
  logic                   mtimecmp_we;
  soc_bus_pkg::bus_data_t mtime_q;
  soc_bus_pkg::bus_data_t mtimecmp_q;
  soc_bus_pkg::bus_data_t rdata_d;
  soc_bus_pkg::bus_data_t rdata_q;
  logic                   rvalid_q;

  assign reg_word    = dev_req_i.offset[11:2];
  assign mtime_we    = dev_req_i.req && dev_req_i.we && (reg_word == MtimeWord);
  assign mtimecmp_we = dev_req_i.req && dev_req_i.we && (reg_word == MtimecmpWord);

  // read mux, unknown words and writes give zero
  always_comb begin
    rdata_d = '0;
    if (!dev_req_i.we) begin
      if (reg_word == MtimeWord) begin
        rdata_d = mtime_q;
      end else if (reg_word == MtimecmpWord) begin
        rdata_d = mtimecmp_q;
      end
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q    <= '0;
      // all ones keeps irq low out of reset
      mtimecmp_q <= '1;
      rvalid_q   <= 1'b0;
    end else begin
      rvalid_q <= dev_req_i.req;
      // write takes the place of the increment
      if (mtime_we) begin
        mtime_q <= soc_bus_pkg::be_merge(mtime_q, dev_req_i.wdata, dev_req_i.be);
      end else begin
        mtime_q <= mtime_q + 32'd1;
      end
      if (mtimecmp_we) begin
        mtimecmp_q <= soc_bus_pkg::be_merge(mtimecmp_q, dev_req_i.wdata, dev_req_i.be);
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (dev_req_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  // level interrupt straight from the registers
  assign irq_timer_o = (mtime_q >= mtimecmp_q);

  assign dev_rsp_o = '{
    rvalid: rvalid_q,
    rdata:  rdata_q
  };

endmodule

// ==== project.f ====
logic/soc_bus_pkg.sv
logic/bus_arbiter.sv
logic/bus_device_mux.sv
logic/sram_device.sv
logic/gpio_device.sv
logic/timer_device.sv
logic/soc_fabric_top.sv
testbench/tb_clock_gen.sv
testbench/tb_soc_fabric.sv

// ==== testbench/tb_clock_gen.sv ====
// testbench clock and reset source
// 40 ns clock, active-low reset held for the first 5 cycles
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HalfPeriodNs = 20,
  parameter int ResetCycles  = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriodNs) clk_o = ~clk_o;
  end

  // release a little after an edge, away from the sampling point
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #2 rst_no = 1'b1;
  end

endmodule

// ==== testbench/tb_soc_fabric.sv ====
// testbench for the shared-bus fabric
// two hosts with random traffic against a ram, gpio and timer model
`timescale 1ns/1ps

module tb_soc_fabric;

  localparam int RamWords   = 1024;
  localparam int GpiWidth   = 8;
  localparam int GpoWidth   = 16;
  localparam int MaxWait    = 50;
  localparam int MaxCycles  = 20000;
  localparam int DriveDelay = 2;
  localparam int TestWords  = 16;

  logic                  clk_sys;
  logic                  rst_sys_n;
  soc_bus_pkg::bus_req_t host_req [soc_bus_pkg::NrHosts];
  soc_bus_pkg::bus_rsp_t host_rsp [soc_bus_pkg::NrHosts];
  logic [GpiWidth-1:0]   gp_in;
  logic [GpoWidth-1:0]   gp_out;
  logic                  irq_timer;

  // reference model
  soc_bus_pkg::bus_data_t ram_model [int];
  logic [GpoWidth-1:0]    gpo_model;
  logic                   irq_exp;

  integer seed;
  int     checks;
  int     errors;
  int     timeouts;

  tb_clock_gen u_clk (
    .clk_o (clk_sys),
    .rst_no(rst_sys_n)
  );

  soc_fabric_top #(
    .RamWords(RamWords),
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth)
  ) uut (
    .clk_sys_i  (clk_sys),
    .rst_sys_ni (rst_sys_n),
    .host_req_i (host_req),
    .host_rsp_o (host_rsp),
    .gp_i       (gp_in),
    .gp_o       (gp_out),
    .irq_timer_o(irq_timer)
  );

  // byte-lane merge of a model word through a lane mask
  function automatic soc_bus_pkg::bus_data_t merge_lanes(soc_bus_pkg::bus_data_t old_word,
                                                         soc_bus_pkg::bus_data_t new_word,
                                                         soc_bus_pkg::bus_be_t be);
    soc_bus_pkg::bus_data_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    checks++;
    if (act_val !== exp_val) begin
      errors++;
      $display("ERR %s expected 0x%08h actual 0x%08h at %0t", name, exp_val, act_val, $time);
    end
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_sys_n !== 1'b1 && cycles < MaxWait) begin
      @(posedge clk_sys);
      cycles++;
    end
    if (rst_sys_n !== 1'b1) begin
      timeouts++;
      $display("timeout: reset was never released");
    end
  endtask

  // one host transaction, request held until gnt, response one cycle later
  task automatic bus_access(input int h, input logic we, input soc_bus_pkg::bus_be_t be,
                            input soc_bus_pkg::bus_addr_t addr,
                            input soc_bus_pkg::bus_data_t wdata,
                            output soc_bus_pkg::bus_data_t rdata, output logic err,
                            output int waits);
    bit granted;
    granted = 1'b0;
    waits   = 0;
    rdata   = '0;
    err     = 1'b1;
    @(posedge clk_sys);
    #(DriveDelay);
    host_req[h] = '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    while (!granted && waits < MaxWait) begin
      @(negedge clk_sys);
      // no response may show up before the grant
      check_value($sformatf("host_rsp[%0d].rvalid", h), 0, host_rsp[h].rvalid);
      if (host_rsp[h].gnt) begin
        granted = 1'b1;
      end else begin
        waits++;
      end
    end
    @(posedge clk_sys);
    #(DriveDelay);
    host_req[h] = '0;
    if (!granted) begin
      timeouts++;
      $display("timeout: host %0d was not granted within %0d cycles", h, MaxWait);
    end else begin
      @(negedge clk_sys);
      check_value($sformatf("host_rsp[%0d].rvalid", h), 1, host_rsp[h].rvalid);
      rdata = host_rsp[h].rdata;
      err   = host_rsp[h].err;
      // writes answer with zero data
      if (we) begin
        check_value($sformatf("host_rsp[%0d].rdata", h), 0, rdata);
      end
    end
  endtask

  task automatic ram_write(input int h, input int word, input soc_bus_pkg::bus_be_t be,
                           input soc_bus_pkg::bus_data_t data);
    soc_bus_pkg::bus_data_t rdata;
    logic                   err;
    int                     waits;
    bus_access(h, 1'b1, be, soc_bus_pkg::RamBase + 32'(word * 4), data, rdata, err, waits);
    check_value("ram write err", 0, err);
    ram_model[word] = merge_lanes(ram_model[word], data, be);
  endtask

  task automatic ram_check(input int h, input int word);
    soc_bus_pkg::bus_data_t rdata;
    logic                   err;
    int                     waits;
    bus_access(h, 1'b0, 4'hf, soc_bus_pkg::RamBase + 32'(word * 4), '0, rdata, err, waits);
    check_value("ram read err", 0, err);
    check_value($sformatf("ram[%0d].rdata", word), ram_model[word], rdata);
  endtask

  task automatic reg_write(input int h, input soc_bus_pkg::bus_addr_t addr,
                           input soc_bus_pkg::bus_be_t be, input soc_bus_pkg::bus_data_t data);
    soc_bus_pkg::bus_data_t rdata;
    logic                   err;
    int                     waits;
    bus_access(h, 1'b1, be, addr, data, rdata, err, waits);
    check_value($sformatf("reg write err @%08h", addr), 0, err);
  endtask

  task automatic reg_read(input int h, input soc_bus_pkg::bus_addr_t addr,
                          output soc_bus_pkg::bus_data_t rdata);
    logic err;
    int   waits;
    bus_access(h, 1'b0, 4'hf, addr, '0, rdata, err, waits);
    check_value($sformatf("reg read err @%08h", addr), 0, err);
  endtask

  // hard stop if the sequence hangs
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < MaxCycles) begin
      @(posedge clk_sys);
      cycles++;
    end
    $display("simulation did not finish within %0d cycles", MaxCycles);
    $display("checks: %0d errors: %0d timeouts: %0d", checks, errors, timeouts);
    $display("Test failures found");
    $finish;
  end

  initial begin
    soc_bus_pkg::bus_data_t rdata;
    soc_bus_pkg::bus_data_t rdata_aux;
    soc_bus_pkg::bus_data_t data_core;
    soc_bus_pkg::bus_data_t data_aux;
    soc_bus_pkg::bus_data_t t_first;
    soc_bus_pkg::bus_data_t t_second;
    soc_bus_pkg::bus_addr_t addr;
    soc_bus_pkg::bus_be_t   be;
    logic                   err;
    logic                   err_aux;
    logic                   we;
    int                     waits;
    int                     core_waits;
    int                     aux_waits;
    seed        = 10752;
    checks      = 0;
    errors      = 0;
    timeouts    = 0;
    host_req[0] = '0;
    host_req[1] = '0;
    gp_in       = '0;
    gpo_model   = '0;
    irq_exp     = 1'b0;
    wait_reset_release();

    // reset state
    @(negedge clk_sys);
    check_value("host_rsp[0].gnt", 0, host_rsp[0].gnt);
    check_value("host_rsp[1].gnt", 0, host_rsp[1].gnt);
    check_value("host_rsp[0].rvalid", 0, host_rsp[0].rvalid);
    check_value("host_rsp[1].rvalid", 0, host_rsp[1].rvalid);
    check_value("irq_timer_o", irq_exp, irq_timer);
    check_value("gp_o", 0, gp_out);

    // full words first, one host per half, running side by side
    fork
      for (int w = 0; w < TestWords / 2; w++) ram_write(0, w, 4'hf, $random(seed));
      for (int w = TestWords / 2; w < TestWords; w++) ram_write(1, w, 4'hf, $random(seed));
    join
    // partial lane writes from a random host
    for (int i = 0; i < 24; i++) begin
      be = soc_bus_pkg::bus_be_t'($random(seed));
      ram_write({$random(seed)} % 2, {$random(seed)} % TestWords, be, $random(seed));
    end
    fork
      for (int w = 0; w < TestWords; w += 2) ram_check(0, w);
      for (int w = 1; w < TestWords; w += 2) ram_check(1, w);
    join

    // same-cycle requests, core has priority
    data_core = $random(seed);
    data_aux  = $random(seed);
    fork
      bus_access(0, 1'b1, 4'hf, 32'd80, data_core, rdata, err, core_waits);
      bus_access(1, 1'b1, 4'hf, 32'd84, data_aux, rdata_aux, err_aux, aux_waits);
    join
    ram_model[20] = data_core;
    ram_model[21] = data_aux;
    check_value("core grant delay", 0, core_waits);
    check_value("aux grant delayed", 1, aux_waits > 0);
    check_value("core write err", 0, err);
    check_value("aux write err", 0, err_aux);
    ram_check(1, 20);
    ram_check(0, 21);

    // unmapped space, plus the hole between gpio and timer
    for (int i = 0; i < 10; i++) begin
      addr = 32'h4000_0000 | ({$random(seed)} & 32'h3fff_fffc);
      if (i == 9) begin
        addr = 32'h8000_1000;
      end
      we = $random(seed);
      bus_access(i % 2, we, 4'hf, addr, $random(seed), rdata, err, waits);
      check_value($sformatf("err @%08h", addr), 1, err);
      check_value($sformatf("rdata @%08h", addr), 0, rdata);
    end
    for (int w = 0; w < TestWords; w++) ram_check(w % 2, w);

    // gpio output register
    for (int i = 0; i < 6; i++) begin
      be        = soc_bus_pkg::bus_be_t'($random(seed));
      data_core = $random(seed);
      reg_write(i % 2, soc_bus_pkg::GpioBase, be, data_core);
      gpo_model = GpoWidth'(merge_lanes(32'(gpo_model), data_core, be));
      check_value("gp_o", 32'(gpo_model), 32'(gp_out));
      reg_read((i + 1) % 2, soc_bus_pkg::GpioBase, rdata);
      check_value("gpio out rdata", 32'(gpo_model), rdata);
    end
    // gpio inputs, held past the two sync flops
    for (int i = 0; i < 4; i++) begin
      @(posedge clk_sys);
      #(DriveDelay);
      gp_in = GpiWidth'($random(seed));
      repeat (3) @(posedge clk_sys);
      reg_read(i % 2, soc_bus_pkg::GpioBase + 32'd4, rdata);
      check_value("gpio in rdata", 32'(gp_in), rdata);
    end

    // timer
    reg_write(0, soc_bus_pkg::TimerBase, 4'hf, 32'd0);
    reg_write(1, soc_bus_pkg::TimerBase + 32'd4, 4'hf, 32'hffff_ffff);
    check_value("irq_timer_o", irq_exp, irq_timer);
    reg_read(1, soc_bus_pkg::TimerBase + 32'd4, rdata);
    check_value("mtimecmp rdata", 32'hffff_ffff, rdata);
    reg_read(0, soc_bus_pkg::TimerBase, t_first);
    reg_read(1, soc_bus_pkg::TimerBase, t_second);
    check_value("mtime increasing", 1, t_second > t_first);
    // compare at zero, irq up right after the write
    reg_write(0, soc_bus_pkg::TimerBase + 32'd4, 4'hf, 32'd0);
    irq_exp = 1'b1;
    check_value("irq_timer_o", irq_exp, irq_timer);
    reg_write(1, soc_bus_pkg::TimerBase + 32'd4, 4'hf, 32'hffff_ffff);
    irq_exp = 1'b0;
    check_value("irq_timer_o", irq_exp, irq_timer);

    $display("checks: %0d errors: %0d timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
